// ==== design/mni_config.svh ====
// Build-time sizing of the network interface input path.
// Include this file wherever a width or threshold below is needed.

`ifndef MNI_CONFIG_SVH
`define MNI_CONFIG_SVH

// Network word and queue geometry
`define MNI_WORD_W        16
`define MNI_NUM_VC        3
`define MNI_LEVEL_W       3
`define MNI_OFFSET_W      6

// Output queue level must exceed this before a VC that may reply is served
`define MNI_NOUT_MIN      2

// Payload words start right after this offset
`define MNI_PAYLOAD_BASE  6

`endif

// ==== design/mniPkg.sv ====
// Shared types of the network interface input path: packet header layout,
// channel vectors, sequencer states and the writeback acknowledge record.

`include "mni_config.svh"

package mniPkg;

  // Word 0 of every incoming packet
  typedef struct packed {
    logic                     spare15;
    logic                     isRead;
    logic                     fault;
    logic [2:0]               spare12to10;
    logic                     hasAck;
    logic [2:0]               spare8to6;
    logic [`MNI_OFFSET_W-1:0] size;
  } headerWord_t;

  // One-hot channel vector, bit 0 is VC0
  typedef logic [`MNI_NUM_VC-1:0] vc_t;

  typedef enum logic [3:0] {
    Idle,
    Peek0,
    Peek2,
    WrFill0,
    WrFill2,
    WrFill3,
    WrFillData,
    WrFill4,
    WrFill5,
    WrFill6,
    WbAck0,
    WbAck2,
    WbAck3,
    Eop
  } seqState_t;

  // Which packet word the writeback capture latches this cycle
  typedef enum logic [2:0] {
    WbNone   = 3'd0,
    WbHeader = 3'd1,
    WbAdrHi  = 3'd2,
    WbAdrLo  = 3'd3,
    WbIssue  = 3'd4
  } wbStep_t;

  typedef struct packed {
    logic        fault;
    logic [31:0] adr;
  } wbAck_t;

endpackage

// ==== design/vcArbiter.sv ====
// Picks the next input virtual channel to serve. A channel is eligible only
// when everything it could produce downstream has room; the grant is held
// for the whole packet and drives the input queue dequeue lines.

`include "mni_config.svh"

module vcArbiter (
  input  logic                      clk_ni,
  input  logic                      rst_ni,
  input  mniPkg::vc_t               i_ninEmpty,
  input  logic [`MNI_LEVEL_W-1:0]   i_noutPacketsVc0,
  input  logic [`MNI_LEVEL_W-1:0]   i_noutPacketsVc1,
  input  logic                      i_wrfillBusy,
  input  logic                      i_grant,
  input  logic                      i_active,
  output logic                      o_eligible,
  output mniPkg::vc_t               o_vc,
  output mniPkg::vc_t               o_ninDeq
);

  localparam logic [`MNI_LEVEL_W-1:0] NoutMin = `MNI_NOUT_MIN;

  mniPkg::vc_t eligible;
  mniPkg::vc_t choice;
  mniPkg::vc_t vcQ;
  logic        vc0Room;
  logic        vc1Room;

  assign vc0Room = (i_noutPacketsVc0 > NoutMin);
  assign vc1Room = (i_noutPacketsVc1 > NoutMin);

  // VC0 only feeds the L2 writeback ack, so it is always serviceable
  assign eligible[0] = ~i_ninEmpty[0];
  assign eligible[1] = ~i_ninEmpty[1] & vc0Room & ~i_wrfillBusy;
  // VC2 traffic may also generate VC1 replies
  assign eligible[2] = ~i_ninEmpty[2] & vc0Room & vc1Room & ~i_wrfillBusy;

  // Fixed priority, lowest VC first
  always_comb begin
    choice = '0;
    if (eligible[0]) choice[0] = 1'b1;
    else if (eligible[1]) choice[1] = 1'b1;
    else if (eligible[2]) choice[2] = 1'b1;
  end

  always_ff @(posedge clk_ni) begin
    if (rst_ni) vcQ <= '0;
    else if (i_grant) vcQ <= choice;
  end

  assign o_eligible = |eligible;
  assign o_vc       = vcQ;
  // New choice already dequeues in the grant cycle so offset 0 is read early
  assign o_ninDeq   = (vcQ & {`MNI_NUM_VC{i_active}}) | (choice & {`MNI_NUM_VC{i_grant}});

  a_vcOneHot: assert property (@(posedge clk_ni) disable iff (rst_ni)
    i_active |-> $onehot(o_vc));

endmodule

// ==== design/packetSequencer.sv ====
// Walks one input packet at a time: reads the header, dispatches to the
// write/fill stream, the L2 writeback ack, or plain discard, and ends each
// packet with a single end-of-packet strobe. Offsets are issued from the
// next state because queue read data returns one cycle later.

`include "mni_config.svh"

module packetSequencer (
  input  logic                      clk_ni,
  input  logic                      rst_ni,
  input  logic                      i_eligible,
  input  mniPkg::vc_t               i_vc,
  input  logic [`MNI_WORD_W-1:0]    i_ninData,
  input  logic                      i_wbAckStall,
  output logic                      o_grant,
  output logic                      o_active,
  output logic [`MNI_OFFSET_W-1:0]  o_ninOffset,
  output logic                      o_ninEop,
  output logic                      o_wrfillValid,
  output mniPkg::wbStep_t           o_wbStep
);

  localparam logic [`MNI_OFFSET_W-1:0] PayloadBase = `MNI_PAYLOAD_BASE;

  mniPkg::seqState_t         stateQ;
  mniPkg::seqState_t         stateD;
  mniPkg::headerWord_t       header;
  logic                      isReadQ;
  logic                      hasAckQ;
  logic [`MNI_OFFSET_W-1:0]  sizeQ;
  logic [`MNI_OFFSET_W-1:0]  offsetCntQ;
  logic [`MNI_OFFSET_W-1:0]  offsetCntD;
  logic [`MNI_OFFSET_W-1:0]  lastOffset;
  logic                      lastPayload;
  logic                      wrfillValidQ;

  assign header = mniPkg::headerWord_t'(i_ninData);

  // ==========================================================================
  // FSM
  // ==========================================================================
  always_comb begin
    stateD = stateQ;
    case (stateQ)
      mniPkg::Idle:  if (i_eligible) stateD = mniPkg::Peek0;
      mniPkg::Peek0: stateD = mniPkg::Peek2;

      // Header fields are valid from here on
      mniPkg::Peek2: begin
        if (i_vc[0]) stateD = mniPkg::WbAck0;
        else if (!isReadQ) stateD = mniPkg::WrFill0;
        else stateD = mniPkg::Eop;
      end

      mniPkg::WrFill0: stateD = mniPkg::WrFill2;
      mniPkg::WrFill2: stateD = mniPkg::WrFill3;
      mniPkg::WrFill3: begin
        // Zero-size writes skip the payload loop
        if (sizeQ != '0) stateD = mniPkg::WrFillData;
        else if (hasAckQ) stateD = mniPkg::WrFill4;
        else stateD = mniPkg::Eop;
      end
      mniPkg::WrFillData: begin
        if (!lastPayload) stateD = mniPkg::WrFillData;
        else if (hasAckQ) stateD = mniPkg::WrFill4;
        else stateD = mniPkg::Eop;
      end
      mniPkg::WrFill4: stateD = mniPkg::WrFill5;
      mniPkg::WrFill5: stateD = mniPkg::WrFill6;
      mniPkg::WrFill6: stateD = mniPkg::Eop;

      mniPkg::WbAck0: stateD = mniPkg::WbAck2;
      mniPkg::WbAck2: stateD = mniPkg::WbAck3;
      mniPkg::WbAck3: if (!i_wbAckStall) stateD = mniPkg::Eop;

      mniPkg::Eop: stateD = mniPkg::Idle;
      default:     stateD = mniPkg::Idle;
    endcase
  end

  always_ff @(posedge clk_ni) begin
    if (rst_ni) begin
      stateQ       <= mniPkg::Idle;
      wrfillValidQ <= 1'b0;
    end else begin
      stateQ <= stateD;
      if (stateD == mniPkg::WrFill0) wrfillValidQ <= 1'b1;
      else if (stateD == mniPkg::Eop) wrfillValidQ <= 1'b0;
    end
  end

  // Header capture, word 0 is on the bus during Peek0
  always_ff @(posedge clk_ni) begin
    if (stateQ == mniPkg::Peek0) begin
      isReadQ <= header.isRead;
      hasAckQ <= header.hasAck;
      sizeQ   <= header.size;
    end
  end

  // ==========================================================================
  // Offset generation
  // ==========================================================================
  assign lastOffset  = sizeQ + PayloadBase;
  assign lastPayload = (offsetCntQ == lastOffset);

  always_comb begin
    if (stateQ == mniPkg::Idle) offsetCntD = PayloadBase;
    else if (stateD == mniPkg::WrFillData) offsetCntD = offsetCntQ + 1'b1;
    else offsetCntD = offsetCntQ;
  end

  always_ff @(posedge clk_ni) begin
    offsetCntQ <= offsetCntD;
  end

  always_comb begin
    case (stateD)
      mniPkg::Peek2,
      mniPkg::WrFill2,
      mniPkg::WbAck2:     o_ninOffset = 'd2;
      mniPkg::WrFill3,
      mniPkg::WbAck3:     o_ninOffset = 'd3;
      mniPkg::WrFill4:    o_ninOffset = 'd4;
      mniPkg::WrFill5:    o_ninOffset = 'd5;
      mniPkg::WrFill6:    o_ninOffset = 'd6;
      mniPkg::WrFillData: o_ninOffset = offsetCntD;
      // Peek0, WrFill0 and WbAck0 all want the header
      default:            o_ninOffset = '0;
    endcase
  end

  // ==========================================================================
  // Outputs
  // ==========================================================================
  assign o_grant       = (stateQ == mniPkg::Idle) & i_eligible;
  assign o_active      = (stateQ != mniPkg::Idle);
  assign o_ninEop      = (stateQ == mniPkg::Eop);
  assign o_wrfillValid = wrfillValidQ;

  always_comb begin
    case (stateQ)
      mniPkg::WbAck0: o_wbStep = mniPkg::WbHeader;
      mniPkg::WbAck2: o_wbStep = mniPkg::WbAdrHi;
      mniPkg::WbAck3: o_wbStep = i_wbAckStall ? mniPkg::WbAdrLo : mniPkg::WbIssue;
      default:        o_wbStep = mniPkg::WbNone;
    endcase
  end

  a_noWrfillOnVc0: assert property (@(posedge clk_ni) disable iff (rst_ni)
    o_wrfillValid |-> !i_vc[0]);

endmodule

// ==== design/wbAckCapture.sv ====
// Builds the L2 writeback acknowledge from packet words as the sequencer
// steps through them, then presents it with a single-cycle valid.

`include "mni_config.svh"

module wbAckCapture (
  input  logic                    clk_ni,
  input  logic                    rst_ni,
  input  mniPkg::wbStep_t         i_wbStep,
  input  logic [`MNI_WORD_W-1:0]  i_ninData,
  output logic                    o_wbAckValid,
  output mniPkg::wbAck_t          o_wbAck
);

  mniPkg::headerWord_t header;
  mniPkg::wbAck_t      wbAckQ;
  logic                validQ;

  assign header = mniPkg::headerWord_t'(i_ninData);

  always_ff @(posedge clk_ni) begin
    if (rst_ni) validQ <= 1'b0;
    else validQ <= (i_wbStep == mniPkg::WbIssue);
  end

  // Low word is still on the bus when the issue step comes
  always_ff @(posedge clk_ni) begin
    if (i_wbStep == mniPkg::WbHeader) wbAckQ.fault <= header.fault;
    if (i_wbStep == mniPkg::WbAdrHi) wbAckQ.adr[`MNI_WORD_W +: `MNI_WORD_W] <= i_ninData;
    if (i_wbStep == mniPkg::WbAdrLo || i_wbStep == mniPkg::WbIssue)
      wbAckQ.adr[0 +: `MNI_WORD_W] <= i_ninData;
  end

  assign o_wbAckValid = validQ;
  assign o_wbAck      = wbAckQ;

  a_singlePulse: assert property (@(posedge clk_ni) disable iff (rst_ni)
    o_wbAckValid |=> !o_wbAckValid);

endmodule

// ==== design/mniIn.sv ====
// Network interface input path top level. Serves the three external VC
// input queues and routes each packet to write/fill, the L2 writeback ack,
// or discard.

`include "mni_config.svh"

module mniIn (
  input  logic                      clk_ni,
  input  logic                      rst_ni,

  // Network in queues
  input  mniPkg::vc_t               i_ninEmpty,
  input  logic [`MNI_LEVEL_W-1:0]   i_noutPacketsVc0,
  input  logic [`MNI_LEVEL_W-1:0]   i_noutPacketsVc1,
  input  logic [`MNI_WORD_W-1:0]    i_ninData,
  output mniPkg::vc_t               o_ninDeq,
  output logic [`MNI_OFFSET_W-1:0]  o_ninOffset,
  output logic                      o_ninEop,

  // Write/fill stream
  input  logic                      i_wrfillBusy,
  output logic                      o_wrfillValid,
  output logic [`MNI_WORD_W-1:0]    o_wrfillData,

  // L2 writeback acknowledge
  input  logic                      i_wbAckStall,
  output logic                      o_wbAckValid,
  output mniPkg::wbAck_t            o_wbAck
);

  logic            eligible;
  logic            grant;
  logic            active;
  mniPkg::vc_t     vc;
  mniPkg::wbStep_t wbStep;

  vcArbiter u_vcArbiter (
    .clk_ni           (clk_ni),
    .rst_ni           (rst_ni),
    .i_ninEmpty       (i_ninEmpty),
    .i_noutPacketsVc0 (i_noutPacketsVc0),
    .i_noutPacketsVc1 (i_noutPacketsVc1),
    .i_wrfillBusy     (i_wrfillBusy),
    .i_grant          (grant),
    .i_active         (active),
    .o_eligible       (eligible),
    .o_vc             (vc),
    .o_ninDeq         (o_ninDeq)
  );

  packetSequencer u_packetSequencer (
    .clk_ni        (clk_ni),
    .rst_ni        (rst_ni),
    .i_eligible    (eligible),
    .i_vc          (vc),
    .i_ninData     (i_ninData),
    .i_wbAckStall  (i_wbAckStall),
    .o_grant       (grant),
    .o_active      (active),
    .o_ninOffset   (o_ninOffset),
    .o_ninEop      (o_ninEop),
    .o_wrfillValid (o_wrfillValid),
    .o_wbStep      (wbStep)
  );

  wbAckCapture u_wbAckCapture (
    .clk_ni       (clk_ni),
    .rst_ni       (rst_ni),
    .i_wbStep     (wbStep),
    .i_ninData    (i_ninData),
    .o_wbAckValid (o_wbAckValid),
    .o_wbAck      (o_wbAck)
  );

  // Queue read data goes out unchanged, qualified by o_wrfillValid
  assign o_wrfillData = i_ninData;

endmodule

// ==== tb/mniInTb.sv ====
// Testbench for the network interface input path. Models the three external
// VC input queues, replays a table of packets and checks the write/fill
// stream, the writeback acknowledge and the order in which packets retire.

`include "mni_config.svh"

module mniInTb;

  // One packet per row; group settings come from the row that closes a group
  typedef struct packed {
    logic [1:0]               vc;
    logic                     isRead;
    logic                     fault;
    logic                     hasAck;
    logic [`MNI_OFFSET_W-1:0] size;
    logic [`MNI_LEVEL_W-1:0]  lvl0;
    logic [`MNI_LEVEL_W-1:0]  lvl1;
    logic                     busy;
    logic [7:0]               stallCycles;
    logic [7:0]               gateCycles;
    logic                     last;
  } stimRow_t;

  localparam int NumRows = 13;
  localparam int WaitLimit = 200;

  logic                     clk_ni;
  logic                     rst_ni;
  mniPkg::vc_t              ninEmpty;
  logic [`MNI_LEVEL_W-1:0]  noutVc0;
  logic [`MNI_LEVEL_W-1:0]  noutVc1;
  logic [`MNI_WORD_W-1:0]   ninData;
  mniPkg::vc_t              ninDeq;
  logic [`MNI_OFFSET_W-1:0] ninOffset;
  logic                     ninEop;
  logic                     wrfillBusy;
  logic                     wrfillValid;
  logic [`MNI_WORD_W-1:0]   wrfillData;
  logic                     wbAckStall;
  logic                     wbAckValid;
  mniPkg::wbAck_t           wbAck;

  // Queue model and scoreboard
  logic [`MNI_WORD_W-1:0]   vcWords [3][$];
  int                       vcLens [3][$];
  logic [`MNI_WORD_W-1:0]   expWr [3][$];
  mniPkg::wbAck_t           expWb [$];
  int                       expOrder [$];
  int                       groupVcs [$];
  stimRow_t                 rows [NumRows];
  logic [31:0]              rng;
  int                       errors;
  int                       checks;
  int                       retired;
  logic                     timedOut;
  logic                     eopS;
  mniPkg::vc_t              deqS;
  logic [`MNI_OFFSET_W-1:0] offS;

  mniIn uut (
    .clk_ni           (clk_ni),
    .rst_ni           (rst_ni),
    .i_ninEmpty       (ninEmpty),
    .i_noutPacketsVc0 (noutVc0),
    .i_noutPacketsVc1 (noutVc1),
    .i_ninData        (ninData),
    .o_ninDeq         (ninDeq),
    .o_ninOffset      (ninOffset),
    .o_ninEop         (ninEop),
    .i_wrfillBusy     (wrfillBusy),
    .o_wrfillValid    (wrfillValid),
    .o_wrfillData     (wrfillData),
    .i_wbAckStall     (wbAckStall),
    .o_wbAckValid     (wbAckValid),
    .o_wbAck          (wbAck)
  );

  initial begin
    clk_ni = 1'b0;
    forever #4 clk_ni = ~clk_ni;
  end

  // ==========================================================================
  // Helpers
  // ==========================================================================
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int vcIndex(input mniPkg::vc_t deq);
    case (deq)
      3'b001:  return 0;
      3'b010:  return 1;
      3'b100:  return 2;
      default: return -1;
    endcase
  endfunction

  function automatic logic [`MNI_WORD_W-1:0] readWord(input int v,
                                                      input logic [`MNI_OFFSET_W-1:0] off);
    if (v < 0) return '0;
    if (int'(off) >= vcWords[v].size()) return '0;
    return vcWords[v][off];
  endfunction

  task automatic checkValue(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic reportError(input string what);
    errors++;
    $display("Error: %s", what);
  endtask

  task automatic updateEmpty();
    int v;
    for (v = 0; v < 3; v++) ninEmpty[v] = (vcLens[v].size() == 0);
  endtask

  // One clock: watch outputs mid-cycle, then answer the queue read
  task automatic tick();
    int v;
    int n;
    @(negedge clk_ni);
    v = vcIndex(ninDeq);
    if (wrfillValid) begin
      if (v < 0) reportError("write/fill valid without a dequeued channel");
      else if (expWr[v].size() == 0) reportError("write/fill word that no packet accounts for");
      else checkValue("o_wrfillData", 64'(wrfillData), 64'(expWr[v].pop_front()));
    end
    if (wbAckValid && wbAckStall) reportError("writeback ack pulsed while stalled");
    if (wbAckValid) begin
      if (expWb.size() == 0) reportError("writeback ack that no packet accounts for");
      else checkValue("o_wbAck", 64'(wbAck), 64'(expWb.pop_front()));
    end
    if (ninEop) begin
      if (expOrder.size() == 0) reportError("end of packet with no packet pending");
      else checkValue("retired VC", 64'(v), 64'(expOrder.pop_front()));
      retired++;
    end
    eopS = ninEop;
    deqS = ninDeq;
    offS = ninOffset;
    @(posedge clk_ni);
    #1;
    v = vcIndex(deqS);
    ninData = readWord(v, offS);
    if (eopS && v >= 0) begin
      n = vcLens[v].pop_front();
      repeat (n) void'(vcWords[v].pop_front());
    end
    updateEmpty();
  endtask

  // ==========================================================================
  // Stimulus
  // ==========================================================================
  task automatic loadPacket(input stimRow_t r);
    logic [`MNI_WORD_W-1:0] w [$];
    int v;
    int i;
    v = int'(r.vc);
    rng = xorshift(rng);
    // Header bits 14, 13, 9 and 5..0, spare bits random
    w.push_back((rng[15:0] & 16'h9dc0) |
                {1'b0, r.isRead, r.fault, 3'b000, r.hasAck, 3'b000, r.size});
    for (i = 1; i < 7 + int'(r.size); i++) begin
      rng = xorshift(rng);
      w.push_back(rng[31:16]);
    end
    for (i = 0; i < w.size(); i++) vcWords[v].push_back(w[i]);
    vcLens[v].push_back(w.size());
    groupVcs.push_back(v);
    if (v == 0) begin
      expWb.push_back(mniPkg::wbAck_t'({r.fault, w[2], w[3]}));
    end else if (!r.isRead) begin
      expWr[v].push_back(w[0]);
      expWr[v].push_back(w[2]);
      expWr[v].push_back(w[3]);
      for (i = 7; i < 7 + int'(r.size); i++) expWr[v].push_back(w[i]);
      if (r.hasAck) for (i = 4; i < 7; i++) expWr[v].push_back(w[i]);
    end
  endtask

  task automatic runGroup(input stimRow_t r);
    int base;
    int target;
    int n;
    int v;
    int k;
    int vc0Count;
    base = retired;
    target = retired + groupVcs.size();
    vc0Count = 0;
    // Fixed priority, so all VC0 packets first, then VC1, then VC2
    for (v = 0; v < 3; v++) begin
      for (k = 0; k < groupVcs.size(); k++) begin
        if (groupVcs[k] == v) begin
          expOrder.push_back(v);
          if (v == 0) vc0Count++;
        end
      end
    end
    groupVcs.delete();
    noutVc0 = r.lvl0;
    noutVc1 = r.lvl1;
    wrfillBusy = r.busy;
    updateEmpty();
    if (r.stallCycles != 0) begin
      wbAckStall = 1'b1;
      repeat (r.stallCycles) tick();
      checkValue("packets retired under stall", 64'(retired - base), 64'd0);
      wbAckStall = 1'b0;
    end
    if (r.gateCycles != 0) begin
      repeat (r.gateCycles) tick();
      checkValue("packets retired while gated", 64'(retired - base), 64'(vc0Count));
      noutVc0 = 3'd4;
      noutVc1 = 3'd4;
      wrfillBusy = 1'b0;
    end
    n = 0;
    while (retired < target && n < WaitLimit) begin
      tick();
      n++;
    end
    if (retired < target) begin
      reportError("timed out waiting for the group's packets to retire");
      timedOut = 1'b1;
    end
    for (v = 0; v < 3; v++) checkValue("write/fill words not seen", 64'(expWr[v].size()), 64'd0);
    checkValue("writeback acks not seen", 64'(expWb.size()), 64'd0);
  endtask

  // Columns: vc, isRead, fault, hasAck, size, lvl0, lvl1, busy, stall, gate, last
  task automatic fillTable();
    rows[0]  = '{2'd0, 1'b0, 1'b1, 1'b0, 6'd0, 3'd4, 3'd4, 1'b0, 8'd0, 8'd0, 1'b1};
    rows[1]  = '{2'd1, 1'b0, 1'b0, 1'b0, 6'd3, 3'd4, 3'd4, 1'b0, 8'd0, 8'd0, 1'b1};
    rows[2]  = '{2'd2, 1'b0, 1'b0, 1'b1, 6'd2, 3'd4, 3'd4, 1'b0, 8'd0, 8'd0, 1'b1};
    rows[3]  = '{2'd1, 1'b1, 1'b0, 1'b0, 6'd2, 3'd4, 3'd4, 1'b0, 8'd0, 8'd0, 1'b1};
    rows[4]  = '{2'd0, 1'b0, 1'b0, 1'b0, 6'd0, 3'd4, 3'd4, 1'b0, 8'd8, 8'd0, 1'b1};
    // All three channels loaded at once
    rows[5]  = '{2'd2, 1'b0, 1'b0, 1'b0, 6'd1, 3'd4, 3'd4, 1'b0, 8'd0, 8'd0, 1'b0};
    rows[6]  = '{2'd1, 1'b0, 1'b1, 1'b1, 6'd2, 3'd4, 3'd4, 1'b0, 8'd0, 8'd0, 1'b0};
    rows[7]  = '{2'd0, 1'b0, 1'b1, 1'b0, 6'd0, 3'd4, 3'd4, 1'b0, 8'd0, 8'd0, 1'b1};
    // VC0 output level at the threshold
    rows[8]  = '{2'd1, 1'b0, 1'b0, 1'b0, 6'd1, 3'd4, 3'd4, 1'b0, 8'd0, 8'd0, 1'b0};
    rows[9]  = '{2'd2, 1'b1, 1'b0, 1'b0, 6'd0, 3'd4, 3'd4, 1'b0, 8'd0, 8'd0, 1'b0};
    rows[10] = '{2'd0, 1'b0, 1'b0, 1'b0, 6'd0, 3'd2, 3'd4, 1'b0, 8'd0, 8'd40, 1'b1};
    // Write/fill busy, plus a zero-size write
    rows[11] = '{2'd2, 1'b0, 1'b0, 1'b1, 6'd0, 3'd4, 3'd4, 1'b0, 8'd0, 8'd0, 1'b0};
    rows[12] = '{2'd0, 1'b0, 1'b1, 1'b0, 6'd0, 3'd4, 3'd4, 1'b1, 8'd0, 8'd40, 1'b1};
  endtask

  initial begin
    int i;
    rst_ni = 1'b1;
    ninEmpty = '1;
    noutVc0 = 3'd4;
    noutVc1 = 3'd4;
    ninData = '0;
    wrfillBusy = 1'b0;
    wbAckStall = 1'b0;
    rng = 32'hcc9d;
    errors = 0;
    checks = 0;
    retired = 0;
    timedOut = 1'b0;
    eopS = 1'b0;
    deqS = '0;
    offS = '0;
    fillTable();
    repeat (2) @(posedge clk_ni);
    #1;
    rst_ni = 1'b0;
    @(negedge clk_ni);
    checkValue("o_ninDeq", 64'(ninDeq), 64'd0);
    checkValue("o_ninEop", 64'(ninEop), 64'd0);
    checkValue("o_wrfillValid", 64'(wrfillValid), 64'd0);
    checkValue("o_wbAckValid", 64'(wbAckValid), 64'd0);
    @(posedge clk_ni);
    #1;
    for (i = 0; i < NumRows && !timedOut; i++) begin
      loadPacket(rows[i]);
      if (rows[i].last) runGroup(rows[i]);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) $display("RESULT: PASS");
    else $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+design
design/mniPkg.sv
design/vcArbiter.sv
design/packetSequencer.sv
design/wbAckCapture.sv
design/mniIn.sv
tb/mniInTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the testbench with Verilator, then judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f src.f --top-module mniInTb \
  && ./obj_dir/VmniInTb > sim.log 2>&1 \
  || { echo "Compile or simulation failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "RESULT: PASS" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
